// File: riscv_pkg.sv
// RV32I subset core package with shared widths, encodings and bundle types
`default_nettype none

package riscv_pkg;

    // ==========================================================
    // Core constants
    // ==========================================================
    localparam int unsigned xlen     = 32;
    localparam int unsigned nregs    = 32;
    // First fetch address out of reset
    localparam logic [xlen-1:0] reset_pc = '0;

    // Basic data and field types
    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [11:0]     imm_i_raw_t;
    typedef logic [11:0]     imm_s_raw_t;
    // Bit 0 always zero for branch and jump offsets
    typedef logic [12:0]     imm_b_raw_t;
    typedef logic [20:0]     imm_j_raw_t;

    // ==========================================================
    // Encodings
    // ==========================================================
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_sra
    } aluop_e;

    // Immediate format select
    typedef enum logic [1:0] {
        immsrc_i,
        immsrc_s,
        immsrc_b,
        immsrc_j
    } immsrc_e;

    // Write-back source select
    typedef enum logic [1:0] {
        res_alu,
        res_mem,
        res_pc_plus4
    } resultsrc_e;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_halt
    } core_state_e;

    // ==========================================================
    // Bundles
    // ==========================================================
    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] funct3;
        logic       funct7_5;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        imm_i_raw_t imm_i_raw;
        imm_s_raw_t imm_s_raw;
        imm_b_raw_t imm_b_raw;
        imm_j_raw_t imm_j_raw;
    } instr_fields_t;

    typedef struct packed {
        logic       reg_write;
        logic       mem_write;
        logic       alu_src;
        aluop_e     alu_control;
        immsrc_e    imm_src;
        resultsrc_e result_src;
        logic       branch;
        logic       branch_ne;
        logic       jump;
        logic       jump_reg;
        logic       halt_req;
    } ctrl_t;

    // Data memory request, write strobe qualified by commit
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } dmem_req_t;

endpackage

`default_nettype wire

// File: alu.sv
// ALU computing add/sub, logic, signed compare and shifts with a zero flag
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  riscv_pkg::word_t  a,
    input  riscv_pkg::word_t  b,
    input  riscv_pkg::aluop_e control,
    output riscv_pkg::word_t  result,
    output logic              zero
);

    // Shift amount from low 5 bits only
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (control)
            riscv_pkg::alu_add: result = a + b;
            riscv_pkg::alu_sub: result = a - b;
            riscv_pkg::alu_and: result = a & b;
            riscv_pkg::alu_or:  result = a | b;
            riscv_pkg::alu_xor: result = a ^ b;
            // Signed compare, result 0 or 1
            riscv_pkg::alu_slt: result = {31'd0, ($signed(a) < $signed(b))};
            riscv_pkg::alu_sll: result = a << shamt;
            riscv_pkg::alu_srl: result = a >> shamt;
            // Arithmetic shift keeps sign
            riscv_pkg::alu_sra: result = $signed(a) >>> shamt;
            default:            result = '0;
        endcase
    end

    // Branch compare flag
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: reg_file.sv
// Integer register file, two async read ports and one clocked write port
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                 clk,
    input  riscv_pkg::reg_addr_t read_reg1,
    input  riscv_pkg::reg_addr_t read_reg2,
    input  riscv_pkg::reg_addr_t write_reg,
    input  riscv_pkg::word_t     write_data,
    input  logic                 write_enable,
    output riscv_pkg::word_t     read_data1,
    output riscv_pkg::word_t     read_data2
);

    riscv_pkg::word_t regs [riscv_pkg::nregs];

    // x0 writes dropped
    always_ff @(posedge clk) begin
        if (write_enable && (write_reg != '0)) begin
            regs[write_reg] <= write_data;
        end
    end

    // x0 always reads as zero
    assign read_data1 = (read_reg1 == '0) ? '0 : regs[read_reg1];
    assign read_data2 = (read_reg2 == '0) ? '0 : regs[read_reg2];

endmodule

`default_nettype wire

// File: control_decoder.sv
// Main and ALU decoder turning instruction fields into datapath controls
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
    input  riscv_pkg::instr_fields_t fields,
    output riscv_pkg::ctrl_t         ctrl
);

    // funct3 to ALU op, sub and sra only for register form
    function automatic riscv_pkg::aluop_e alu_decode(
        input logic [2:0] funct3,
        input logic       funct7_5,
        input logic       reg_form
    );
        riscv_pkg::aluop_e op;
        case (funct3)
            3'b000: begin
                if (reg_form && funct7_5) begin
                    op = riscv_pkg::alu_sub;
                end else begin
                    op = riscv_pkg::alu_add;
                end
            end
            3'b001: op = riscv_pkg::alu_sll;
            3'b010: op = riscv_pkg::alu_slt;
            3'b100: op = riscv_pkg::alu_xor;
            3'b101: begin
                if (reg_form && funct7_5) begin
                    op = riscv_pkg::alu_sra;
                end else begin
                    op = riscv_pkg::alu_srl;
                end
            end
            3'b110: op = riscv_pkg::alu_or;
            3'b111: op = riscv_pkg::alu_and;
            // sltu not in the subset
            default: op = riscv_pkg::alu_add;
        endcase
        return op;
    endfunction

    always_comb begin
        // Safe defaults, nothing written
        ctrl             = '0;
        ctrl.alu_control = riscv_pkg::alu_add;
        ctrl.imm_src     = riscv_pkg::immsrc_i;
        ctrl.result_src  = riscv_pkg::res_alu;

        case (fields.opcode)
            riscv_pkg::opc_op: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_control = alu_decode(fields.funct3, fields.funct7_5, 1'b1);
            end
            riscv_pkg::opc_op_imm: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src     = 1'b1;
                ctrl.alu_control = alu_decode(fields.funct3, fields.funct7_5, 1'b0);
            end
            // lw, address is rs1 + imm
            riscv_pkg::opc_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.result_src = riscv_pkg::res_mem;
            end
            riscv_pkg::opc_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.imm_src   = riscv_pkg::immsrc_s;
            end
            // beq/bne compare through subtraction
            riscv_pkg::opc_branch: begin
                ctrl.branch      = 1'b1;
                ctrl.branch_ne   = fields.funct3[0];
                ctrl.imm_src     = riscv_pkg::immsrc_b;
                ctrl.alu_control = riscv_pkg::alu_sub;
            end
            riscv_pkg::opc_jal: begin
                ctrl.reg_write  = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.imm_src    = riscv_pkg::immsrc_j;
                ctrl.result_src = riscv_pkg::res_pc_plus4;
            end
            // Target from ALU, link is pc + 4
            riscv_pkg::opc_jalr: begin
                ctrl.reg_write  = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.jump_reg   = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.result_src = riscv_pkg::res_pc_plus4;
            end
            // ecall and anything unknown stop the core
            default: begin
                ctrl.halt_req = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: run_control_fsm.sv
// Run-control FSM starting execution after reset and holding at halt
`timescale 1ns/1ps
`default_nettype none

module run_control_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic halt_req,
    output logic commit,
    output logic halted
);

    riscv_pkg::core_state_e state_q;
    riscv_pkg::core_state_e state_d;

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            riscv_pkg::st_idle: state_d = riscv_pkg::st_run;
            riscv_pkg::st_run: begin
                if (halt_req) begin
                    state_d = riscv_pkg::st_halt;
                end
            end
            // Sticky until reset
            riscv_pkg::st_halt: state_d = riscv_pkg::st_halt;
            default:            state_d = riscv_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= riscv_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Halting instruction itself never commits
    assign commit = (state_q == riscv_pkg::st_run) && !halt_req;
    assign halted = (state_q == riscv_pkg::st_halt);

endmodule

`default_nettype wire

// File: retire_counter.sv
// Retired-instruction counter, one count per committed cycle
`timescale 1ns/1ps
`default_nettype none

module retire_counter (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             commit,
    output riscv_pkg::word_t instret
);

    riscv_pkg::word_t count_q;

    // Wraps at 2^32
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (commit) begin
            count_q <= count_q + 32'd1;
        end
    end

    assign instret = count_q;

endmodule

`default_nettype wire

// File: datapath.sv
// Single-cycle datapath with PC, immediates, operand muxes, ALU and register file
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  logic                     clk,
    input  logic                     rst_n,
    input  riscv_pkg::instr_fields_t fields,
    input  riscv_pkg::ctrl_t         ctrl,
    input  logic                     commit,
    input  riscv_pkg::word_t         dmem_rdata,
    output riscv_pkg::word_t         pc,
    output riscv_pkg::dmem_req_t     dmem_req
);

    riscv_pkg::word_t pc_q;
    riscv_pkg::word_t pc_next;
    riscv_pkg::word_t pc_plus4;
    riscv_pkg::word_t pc_target;
    riscv_pkg::word_t jalr_target;
    riscv_pkg::word_t imm_ext;
    riscv_pkg::word_t rd1;
    riscv_pkg::word_t rd2;
    riscv_pkg::word_t src_b;
    riscv_pkg::word_t alu_result;
    riscv_pkg::word_t result;
    logic             zero;
    logic             take;

    // ==========================================================
    // Immediate extension
    // ==========================================================
    always_comb begin
        case (ctrl.imm_src)
            riscv_pkg::immsrc_s: imm_ext = {{20{fields.imm_s_raw[11]}}, fields.imm_s_raw};
            riscv_pkg::immsrc_b: imm_ext = {{19{fields.imm_b_raw[12]}}, fields.imm_b_raw};
            riscv_pkg::immsrc_j: imm_ext = {{11{fields.imm_j_raw[20]}}, fields.imm_j_raw};
            default:             imm_ext = {{20{fields.imm_i_raw[11]}}, fields.imm_i_raw};
        endcase
    end

    // ==========================================================
    // Program counter
    // ==========================================================
    assign pc_plus4  = pc_q + 32'd4;
    assign pc_target = pc_q + imm_ext;
    // jalr target, rs1 + imm with bit 0 dropped
    assign jalr_target = {alu_result[31:1], 1'b0};

    // Branch taken when compare disagrees with the ne polarity
    assign take = (ctrl.branch && (zero != ctrl.branch_ne)) || ctrl.jump;

    always_comb begin
        if (!take) begin
            pc_next = pc_plus4;
        end else if (ctrl.jump_reg) begin
            pc_next = jalr_target;
        end else begin
            pc_next = pc_target;
        end
    end

    // Only advances on a committed instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= riscv_pkg::reset_pc;
        end else if (commit) begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

    // ==========================================================
    // Register file and ALU
    // ==========================================================
    reg_file u_reg_file (
        .clk          (clk),
        .read_reg1    (fields.rs1),
        .read_reg2    (fields.rs2),
        .write_reg    (fields.rd),
        .write_data   (result),
        .write_enable (ctrl.reg_write && commit),
        .read_data1   (rd1),
        .read_data2   (rd2)
    );

    // B operand, register or immediate
    assign src_b = ctrl.alu_src ? imm_ext : rd2;

    alu u_alu (
        .a       (rd1),
        .b       (src_b),
        .control (ctrl.alu_control),
        .result  (alu_result),
        .zero    (zero)
    );

    // Write-back select
    always_comb begin
        case (ctrl.result_src)
            riscv_pkg::res_mem:      result = dmem_rdata;
            riscv_pkg::res_pc_plus4: result = pc_plus4;
            default:                 result = alu_result;
        endcase
    end

    // Memory request, address from ALU and data from rs2
    assign dmem_req.addr  = alu_result;
    assign dmem_req.wdata = rd2;
    assign dmem_req.we    = ctrl.mem_write && commit;

endmodule

`default_nettype wire

// File: riscv_core.sv
// Single-cycle RV32I subset core top, field slicing and block wiring
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
    input  logic                 clk,
    input  logic                 rst_n,
    output riscv_pkg::word_t     imem_addr,
    input  riscv_pkg::word_t     imem_rdata,
    output riscv_pkg::dmem_req_t dmem_req,
    input  riscv_pkg::word_t     dmem_rdata,
    output logic                 halted,
    output riscv_pkg::word_t     instret
);

    riscv_pkg::instr_fields_t fields;
    riscv_pkg::ctrl_t         ctrl;
    logic                     commit;

    // ==========================================================
    // Instruction field split
    // ==========================================================
    always_comb begin
        fields.opcode    = riscv_pkg::opcode_e'(imem_rdata[6:0]);
        fields.funct3    = imem_rdata[14:12];
        fields.funct7_5  = imem_rdata[30];
        fields.rs1       = imem_rdata[19:15];
        fields.rs2       = imem_rdata[24:20];
        fields.rd        = imem_rdata[11:7];
        fields.imm_i_raw = imem_rdata[31:20];
        fields.imm_s_raw = {imem_rdata[31:25], imem_rdata[11:7]};
        // B and J offsets are scattered, bit 0 implied zero
        fields.imm_b_raw = {imem_rdata[31], imem_rdata[7], imem_rdata[30:25],
                            imem_rdata[11:8], 1'b0};
        fields.imm_j_raw = {imem_rdata[31], imem_rdata[19:12], imem_rdata[20],
                            imem_rdata[30:21], 1'b0};
    end

    control_decoder u_control_decoder (
        .fields (fields),
        .ctrl   (ctrl)
    );

    run_control_fsm u_run_control_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .halt_req (ctrl.halt_req),
        .commit   (commit),
        .halted   (halted)
    );

    // PC drives the fetch address directly
    datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .fields     (fields),
        .ctrl       (ctrl),
        .commit     (commit),
        .dmem_rdata (dmem_rdata),
        .pc         (imem_addr),
        .dmem_req   (dmem_req)
    );

    retire_counter u_retire_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .commit  (commit),
        .instret (instret)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// Testbench clock source, free-running 10 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    localparam int period_ns = 10;

    initial clk = 1'b0;

    // Half period toggle
    always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: tb_riscv_core.sv
// Testbench for the single-cycle core with memories, ISA reference model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core;

    localparam int reset_cycles = 8;
    localparam int max_cycles   = 200;
    localparam int n_programs   = 4;
    localparam int clk_ns       = 10;
    // Four programs of worst case length with double margin
    localparam int watchdog_ns  = 2 * n_programs * max_cycles * clk_ns;
    localparam logic [31:0] lfsr_seed = 32'hda96d54b;
    localparam logic [31:0] ecall     = 32'h00000073;

    // Expected effects of one instruction
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
        logic        halt;
    } step_t;

    logic                 clk;
    logic                 rst_n;
    riscv_pkg::word_t     imem_addr;
    riscv_pkg::word_t     imem_rdata;
    riscv_pkg::dmem_req_t dmem_req;
    riscv_pkg::word_t     dmem_rdata;
    logic                 halted;
    riscv_pkg::word_t     instret;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];

    // Reference model state
    logic [31:0] m_regs [32];
    logic [31:0] m_mem [256];
    logic [31:0] m_pc;
    int          m_count;

    logic [31:0] lfsr_q;
    int          pc_idx;
    logic        running;
    logic        halt_seen;
    int          n_checks;
    int          n_errors;
    int          tests_passed;
    int          tests_failed;

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    riscv_core dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .halted     (halted),
        .instret    (instret)
    );

    // ==========================================================
    // Zero-wait memories
    // ==========================================================
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    always @(posedge clk) begin
        if (dmem_req.we === 1'b1) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
    end

    // ==========================================================
    // Random numbers and instruction encoding
    // ==========================================================
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, riscv_pkg::opc_op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // Always sw
    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], riscv_pkg::opc_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscv_pkg::opc_branch};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_pkg::opc_jal};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[pc_idx] = w;
        pc_idx++;
    endtask

    // Background data where every word differs
    function automatic logic [31:0] fill_word(input int i);
        return (32'h9e3779b9 * (i + 1)) ^ (i << 16);
    endfunction

    // ==========================================================
    // Reference ISA model
    // ==========================================================
    function automatic logic [31:0] expected_alu(input logic [2:0] f3, input logic alt,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            // Sign fill for the arithmetic form
            3'b101:  return (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'd0);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // One instruction at m_pc updating model state
    function automatic step_t ref_step();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic        wr;
        step_t       out;
        ins     = imem[m_pc[9:2]];
        a       = m_regs[ins[19:15]];
        b       = m_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        out     = '0;
        wr      = 1'b1;
        res     = 32'd0;
        next_pc = m_pc + 32'd4;
        case (ins[6:0])
            7'b0110011: res = expected_alu(ins[14:12], ins[30], a, b);
            7'b0010011: res = expected_alu(ins[14:12], 1'b0, a, imm_i);
            7'b0000011: res = m_mem[(a + imm_i) >> 2 & 32'hff];
            7'b0100011: begin
                wr        = 1'b0;
                out.we    = 1'b1;
                out.addr  = a + imm_s;
                out.wdata = b;
                m_mem[out.addr[9:2]] = b;
            end
            7'b1100011: begin
                wr = 1'b0;
                if ((a == b) != ins[12]) begin
                    next_pc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                res     = m_pc + 32'd4;
                next_pc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b1100111: begin
                res     = m_pc + 32'd4;
                next_pc = (a + imm_i) & 32'hfffffffe;
            end
            // ecall and unknown opcodes freeze everything
            default: begin
                wr       = 1'b0;
                out.halt = 1'b1;
                next_pc  = m_pc;
            end
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            m_regs[ins[11:7]] = res;
        end
        if (!out.halt) begin
            m_count++;
        end
        m_pc = next_pc;
        return out;
    endfunction

    // ==========================================================
    // Checking
    // ==========================================================
    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("ERROR t=%0t %s expected %h got %h", $time, name, want, got);
        end
    endtask

    task automatic check_reset_outputs();
        check_word("imem_addr", imem_addr, 32'd0);
        check_word("dmem_req.we", {31'd0, dmem_req.we}, 32'd0);
        check_word("halted", {31'd0, halted}, 32'd0);
        check_word("instret", instret, 32'd0);
    endtask

    // Compare one cycle of the DUT against the model
    always @(negedge clk) begin : compare_proc
        step_t       ref_out;
        logic [31:0] pc_want;
        if (running) begin
            pc_want = m_pc;
            ref_out = ref_step();
            check_word("imem_addr", imem_addr, pc_want);
            check_word("halted", {31'd0, halted}, 32'd0);
            check_word("dmem_req.we", {31'd0, dmem_req.we}, {31'd0, ref_out.we});
            if (ref_out.we) begin
                check_word("dmem_req.addr", dmem_req.addr, ref_out.addr);
                check_word("dmem_req.wdata", dmem_req.wdata, ref_out.wdata);
            end
            if (ref_out.halt) begin
                running   = 1'b0;
                halt_seen = 1'b1;
            end
        end
    end

    // ==========================================================
    // Programs
    // ==========================================================
    task automatic clear_memories();
        for (int i = 0; i < 256; i++) begin
            imem[i]  = 32'd0;
            dmem[i]  = fill_word(i);
            m_mem[i] = fill_word(i);
        end
    endtask

    // Registers persist across reset in both DUT and model
    task automatic begin_reset();
        @(posedge clk);
        #1;
        rst_n     = 1'b0;
        running   = 1'b0;
        halt_seen = 1'b0;
        clear_memories();
        m_pc    = 32'd0;
        m_count = 0;
        pc_idx  = 0;
    endtask

    task automatic build_arith();
        logic [2:0] r_f3 [8];
        logic [2:0] i_f3 [8];
        logic [2:0] f3;
        logic       alt;
        r_f3 = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101, 3'b110, 3'b111, 3'b000};
        i_f3 = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111, 3'b000, 3'b100, 3'b110};
        for (int r = 1; r < 32; r++) begin
            emit(i_type(12'(take_bits(12)), 5'd0, 3'b000, 5'(r), riscv_pkg::opc_op_imm));
        end
        for (int k = 0; k < 40; k++) begin
            if (take_bits(1) != 0) begin
                f3  = r_f3[3'(take_bits(3))];
                alt = (f3 == 3'b000 || f3 == 3'b101) ? (take_bits(1) != 0) : 1'b0;
                emit(r_type({1'b0, alt, 5'd0}, 5'(take_bits(5)), 5'(take_bits(5)), f3,
                            5'(take_bits(5))));
            end else begin
                f3 = i_f3[3'(take_bits(3))];
                emit(i_type(12'(take_bits(12)), 5'(take_bits(5)), f3, 5'(take_bits(5)),
                            riscv_pkg::opc_op_imm));
            end
        end
        // x0 as destination in both forms
        emit(r_type(7'd0, 5'd2, 5'd1, 3'b000, 5'd0));
        emit(i_type(12'h7ff, 5'd3, 3'b000, 5'd0, riscv_pkg::opc_op_imm));
        for (int r = 0; r < 32; r++) begin
            emit(s_type(12'(4 * r), 5'(r), 5'd0));
        end
        emit(ecall);
    endtask

    task automatic build_memory();
        logic [11:0] offs [12];
        for (int i = 0; i < 12; i++) begin
            offs[i] = 12'(take_bits(7) * 4);
            emit(s_type(offs[i], 5'(take_bits(5)), 5'd0));
        end
        for (int i = 0; i < 12; i++) begin
            emit(i_type(offs[i], 5'd0, 3'b010, 5'(i + 1), riscv_pkg::opc_load));
        end
        // Copies land in the upper half
        for (int i = 0; i < 12; i++) begin
            emit(s_type(offs[i] + 12'd512, 5'(i + 1), 5'd0));
        end
        emit(ecall);
    endtask

    task automatic build_control();
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd1, riscv_pkg::opc_op_imm));
        emit(i_type(12'd0, 5'd0, 3'b000, 5'd3, riscv_pkg::opc_op_imm));
        for (int k = 0; k < 10; k++) begin
            // x2 is 5 or 6 so beq/bne goes either way
            emit(i_type(12'(5 + take_bits(1)), 5'd0, 3'b000, 5'd2, riscv_pkg::opc_op_imm));
            emit(b_type(13'd8, 5'd2, 5'd1, (take_bits(1) != 0) ? 3'b001 : 3'b000));
            emit(i_type(12'd1, 5'd3, 3'b000, 5'd3, riscv_pkg::opc_op_imm));
            emit(j_type(21'd8, 5'd4));
            emit(i_type(12'd100, 5'd3, 3'b000, 5'd3, riscv_pkg::opc_op_imm));
            // Lands on the first link store
            emit(i_type(12'd12, 5'd4, 3'b000, 5'd5, riscv_pkg::opc_jalr));
            emit(i_type(12'd1000, 5'd3, 3'b000, 5'd3, riscv_pkg::opc_op_imm));
            emit(s_type(12'(8 * k), 5'd4, 5'd0));
            emit(s_type(12'(8 * k + 4), 5'd5, 5'd0));
        end
        emit(s_type(12'd128, 5'd3, 5'd0));
        emit(ecall);
    endtask

    task automatic build_unknown();
        logic [31:0] w;
        w = take_bits(25);
        emit(i_type(12'(take_bits(12)), 5'd0, 3'b000, 5'd6, riscv_pkg::opc_op_imm));
        emit(s_type(12'd16, 5'd6, 5'd0));
        // custom-0 opcode outside the subset
        emit({w[24:0], 7'b0001011});
        emit(s_type(12'd20, 5'd6, 5'd0));
        emit(ecall);
    endtask

    task automatic run_program(input string name);
        int err_start;
        int cycles;
        err_start = n_errors;
        for (int i = 0; i < reset_cycles - 1; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Still idle before the first edge out of reset
        @(negedge clk);
        check_reset_outputs();
        @(posedge clk);
        running = 1'b1;
        cycles  = 0;
        while (!halt_seen && cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if (!halt_seen) begin
            running = 1'b0;
            n_errors++;
            $display("Program %s did not halt within %0d cycles", name, max_cycles);
        end else begin
            for (int i = 0; i < 4; i++) begin
                @(negedge clk);
                check_word("halted", {31'd0, halted}, 32'd1);
                check_word("imem_addr", imem_addr, m_pc);
                check_word("dmem_req.we", {31'd0, dmem_req.we}, 32'd0);
                check_word("instret", instret, 32'(m_count));
            end
        end
        for (int i = 0; i < 256; i++) begin
            check_word($sformatf("dmem[%0d]", i), dmem[i], m_mem[i]);
        end
        if (n_errors == err_start) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("test %-8s %s, %0d errors", name,
                 (n_errors == err_start) ? "ok" : "FAILED", n_errors - err_start);
    endtask

    // ==========================================================
    // Sequence and watchdog
    // ==========================================================
    initial begin
        rst_n        = 1'b0;
        running      = 1'b0;
        halt_seen    = 1'b0;
        n_checks     = 0;
        n_errors     = 0;
        tests_passed = 0;
        tests_failed = 0;
        pc_idx       = 0;
        lfsr_q       = lfsr_seed;
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = 32'd0;
        end
        clear_memories();

        begin_reset();
        build_arith();
        run_program("arith");
        begin_reset();
        build_memory();
        run_program("memory");
        begin_reset();
        build_control();
        run_program("control");
        begin_reset();
        build_unknown();
        run_program("unknown");

        $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired, the run did not finish within %0d ns", watchdog_ns);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
riscv_pkg.sv
alu.sv
reg_file.sv
control_decoder.sv
run_control_fsm.sv
retire_counter.sv
datapath.sv
riscv_core.sv
tb_clock_gen.sv
tb_riscv_core.sv

// File: Bender.yml
package:
  name: riscv_core

sources:
  - riscv_pkg.sv
  - alu.sv
  - reg_file.sv
  - control_decoder.sv
  - run_control_fsm.sv
  - retire_counter.sv
  - datapath.sv
  - riscv_core.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_riscv_core.sv
